// ==== Makefile ====
# Verilator build and run for the KD-tree search engine

VERILATOR ?= verilator
TOP       ?= kd_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= PASS: all tests

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard source/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Status follows the pass line in the output
run: $(SIM)
	@out="$$(./$(SIM) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/kd_checker.sv ====
/*
 Concurrent assertions for the KD-tree search engine
 Four-phase ack ordering and the fixed query-to-leaf latency, bound to the top
*/

`timescale 1ns/1ps
`default_nettype none

`include "kd_params.svh"

module kd_checker (
  input logic clk,
  input logic rst_n,
  input logic node_req,
  input logic node_ack,
  input logic query_valid,
  input logic leaf_valid
);

  int fail_count = 0;  // Read by the testbench top

  // Loader raised ack off an edge where req was high
  ack_rise_with_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(node_ack) |-> $past(node_req))
    else begin
      $error("node_ack rose while node_req was low");
      fail_count = fail_count + 1;
    end

  // Ack only returns low once the host has let go
  ack_fall_without_req: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(node_ack) |-> !$past(node_req))
    else begin
      $error("node_ack fell while node_req was still high");
      fail_count = fail_count + 1;
    end

  // Leaf register updates at the sixth edge, sampled one edge later
  leaf_latency: assert property (@(posedge clk) disable iff (!rst_n)
    leaf_valid == $past(query_valid, `KD_DEPTH + 1))
    else begin
      $error("leaf_valid does not follow query_valid by the pipeline depth");
      fail_count = fail_count + 1;
    end

endmodule

bind kd_search_top kd_checker u_checker (
  .clk         (clk),
  .rst_n       (rst_n),
  .node_req    (node_req),
  .node_ack    (node_ack),
  .query_valid (query_valid),
  .leaf_valid  (leaf_valid)
);

`default_nettype wire

// ==== dv/kd_clock_gen.sv ====
/*
 Testbench clock and reset source
 10 ns clock, synchronous active-low reset held for two cycles
*/

`timescale 1ns/1ps
`default_nettype none

module kd_clock_gen (
  output logic clk,
  output logic rst_n
);

  initial clk = 1'b0;
  always #5 clk = ~clk;  // 10 ns period

  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;  // Released off the edge like all other inputs
  end

endmodule

`default_nettype wire

// ==== dv/kd_monitor.sv ====
/*
 Monitor and scoreboard for the KD-tree search engine
 Mirrors node loads into a reference tree, predicts leaves, compares in order
*/

`timescale 1ns/1ps
`default_nettype none

`include "kd_params.svh"

module kd_monitor
  import kd_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      node_req,
  input  node_word_t                node_wdata,
  input  logic                      node_ack,
  input  logic                      query_valid,
  input  patch_t                    query_patch,
  input  logic                      leaf_valid,
  input  logic [`KD_LEAF_WIDTH-1:0] leaf_index,
  input  int                        test_id,     // Current test, for error lines
  output int                        errors,
  output int                        pending      // Results still owed by the DUT
);

  node_word_t                model [`KD_NUM_NODES];  // Reference tree, heap order
  node_word_t                pend_word;              // Word of the running transfer
  int                        addr;
  int                        cyc;                    // Edge counter
  int                        checked;
  logic                      ack_prev;
  logic                      rst_prev;
  logic [`KD_LEAF_WIDTH-1:0] exp_leaf [$];
  int                        exp_due [$];            // Edge at which the leaf updates

  initial begin
    errors   = 0;
    pending  = 0;
    cyc      = 0;
    checked  = 0;
    addr     = 0;
    ack_prev = 1'b0;
    rst_prev = 1'b0;
  end

  function automatic string test_label(input int id);
    case (id)
      1: return "reset";
      2: return "single_queries";
      3: return "back_to_back";
      4: return "threshold_edge";
      5: return "reload_wrap";
      6: return "random_gaps";
      default: return "unknown";
    endcase
  endfunction

  // Walk of the reference tree, right on greater or equal
  function automatic logic [`KD_LEAF_WIDTH-1:0] expected_leaf(input patch_t p);
    int                        k;
    int                        d;
    logic [`KD_COMP_WIDTH-1:0] c;
    logic [`KD_LEAF_WIDTH-1:0] path;
    logic                      right;
    k    = 0;
    path = '0;
    for (int lvl = 0; lvl < `KD_DEPTH; lvl++) begin
      d = int'(model[k].split_dim);
      if (d > `KD_NUM_COMPS - 1) d = `KD_NUM_COMPS - 1;  // Dims 5 to 7 clamp
      c     = p.flat[d*`KD_COMP_WIDTH +: `KD_COMP_WIDTH];
      right = (c >= model[k].threshold);
      path  = {path[`KD_LEAF_WIDTH-2:0], right};           // First decision ends up on top
      k     = 2 * k + 1 + int'(right);
    end
    return path;
  endfunction

  always @(posedge clk) begin
    if (!rst_n) begin
      for (int n = 0; n < `KD_NUM_NODES; n++) model[n] = '0;
      addr     = 0;
      ack_prev = 1'b0;
      exp_leaf.delete();
      exp_due.delete();
    end else begin
      if (!rst_prev && node_ack !== 1'b0) begin
        errors++;
        $display("Fail %s: node_ack expected 0 actual %0d", test_label(test_id), node_ack);
      end
      // Outputs seen here were set at the previous edge
      if (exp_due.size() > 0 && exp_due[0] == cyc - 1) begin
        checked++;
        if (leaf_valid !== 1'b1) begin
          errors++;
          $display("Fail %s: leaf_valid expected 1 actual %0d", test_label(test_id), leaf_valid);
        end else if (leaf_index !== exp_leaf[0]) begin
          errors++;
          $display("Fail %s: leaf_index expected %0d actual %0d",
                   test_label(test_id), exp_leaf[0], leaf_index);
        end
        void'(exp_leaf.pop_front());
        void'(exp_due.pop_front());
      end else if (leaf_valid !== 1'b0) begin
        errors++;
        $display("Fail %s: leaf_valid expected 0 actual %0d", test_label(test_id), leaf_valid);
      end
      if (node_req && !node_ack) pend_word = node_wdata;  // Held stable until ack
      if (node_ack && !ack_prev) begin                    // Transfer completed
        model[addr] = pend_word;
        addr = (addr == `KD_NUM_NODES - 1) ? 0 : addr + 1;
      end
      ack_prev = node_ack;
      if (query_valid) begin
        exp_leaf.push_back(expected_leaf(query_patch));
        exp_due.push_back(cyc + `KD_DEPTH);
      end
    end
    pending  = exp_due.size();
    rst_prev = rst_n;
    cyc++;
  end

  task automatic print_summary(input int assert_fails);
    $display("Summary: %0d results checked, %0d mismatches, %0d assertion failures",
             checked, errors, assert_fails);
  endtask

endmodule

`default_nettype wire

// ==== dv/kd_tb.sv ====
/*
 Testbench top for the KD-tree search engine
 Clock and reset, DUT, monitor, req/ack node loading and the query tests
*/

`timescale 1ns/1ps
`default_nettype none

`include "kd_params.svh"

module kd_tb
  import kd_pkg::*;
();

  localparam int ACK_TIMEOUT   = 20;   // Cycles per handshake phase
  localparam int DRAIN_TIMEOUT = 40;
  localparam int RESET_TIMEOUT = 20;

  logic                      clk;
  logic                      rst_n;
  logic                      node_req;
  node_word_t                node_wdata;
  logic                      node_ack;
  logic                      query_valid;
  patch_t                    query_patch;
  logic                      leaf_valid;
  logic [`KD_LEAF_WIDTH-1:0] leaf_index;
  integer                    seed;
  int                        test_id;
  int                        mon_errors;
  int                        pending;
  node_word_t                root_word;   // Node 0 of the latest load

  kd_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

  kd_search_top UUT (
    .clk(clk), .rst_n(rst_n), .node_req(node_req), .node_wdata(node_wdata),
    .node_ack(node_ack), .query_valid(query_valid), .query_patch(query_patch),
    .leaf_valid(leaf_valid), .leaf_index(leaf_index)
  );

  kd_monitor u_mon (
    .clk(clk), .rst_n(rst_n), .node_req(node_req), .node_wdata(node_wdata),
    .node_ack(node_ack), .query_valid(query_valid), .query_patch(query_patch),
    .leaf_valid(leaf_valid), .leaf_index(leaf_index), .test_id(test_id),
    .errors(mon_errors), .pending(pending)
  );

  function automatic patch_t rand_patch();
    patch_t p;
    p.flat = `KD_PATCH_WIDTH'({$random(seed), $random(seed)});
    return p;
  endfunction

  function automatic node_word_t rand_word();
    node_word_t w;
    w.split_dim = `KD_DIM_WIDTH'($random(seed));   // Full range, 5 to 7 included
    w.threshold = `KD_COMP_WIDTH'($random(seed));
    return w;
  endfunction

  task automatic stop_on_timeout(input string what);
    $display("Timeout: %s", what);
    $display("FAIL: see errors above");
    $finish;
  endtask

  task automatic wait_ack(input logic level, output logic ok);
    int t;
    t = 0;
    while (node_ack !== level && t < ACK_TIMEOUT) begin
      @(posedge clk);
      #1;
      t++;
    end
    ok = (node_ack === level);
  endtask

  // One four-phase transfer, entered 1 ns after an edge
  task automatic load_word(input node_word_t w);
    logic ok;
    node_wdata = w;
    node_req   = 1'b1;
    wait_ack(1'b1, ok);
    if (!ok) begin
      stop_on_timeout("handshake stalled, node_ack never rose");
    end else begin
      node_req = 1'b0;
      wait_ack(1'b0, ok);
      if (!ok) stop_on_timeout("handshake stalled, node_ack stayed high");
    end
  endtask

  task automatic load_tree();
    node_word_t w;
    for (int i = 0; i < `KD_NUM_NODES; i++) begin
      w = rand_word();
      if (i == 0) root_word = w;
      load_word(w);
    end
  endtask

  task automatic put_query(input logic v, input patch_t p);
    query_valid = v;
    query_patch = p;
    @(posedge clk);
    #1;
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (pending != 0 && t < DRAIN_TIMEOUT) begin
      @(posedge clk);
      #1;
      t++;
    end
    if (pending != 0) stop_on_timeout("queries still waiting for a result");
  endtask

  initial begin
    int     t;
    int     d;
    patch_t p;
    seed        = 32'hfc780e75;
    test_id     = 1;
    node_req    = 1'b0;
    node_wdata  = '0;
    query_valid = 1'b0;
    query_patch = '0;
    t = 0;
    while (rst_n !== 1'b1 && t < RESET_TIMEOUT) begin
      @(posedge clk);
      #1;
      t++;
    end
    if (rst_n !== 1'b1) stop_on_timeout("reset was never released");
    put_query(1'b0, '0);
    put_query(1'b1, rand_patch());  // Empty tree sends this to leaf 63
    put_query(1'b0, '0);
    wait_drain();
    test_id = 2;
    load_tree();
    repeat (200) begin
      put_query(1'b1, rand_patch());
      repeat (1 + ($random(seed) & 3)) put_query(1'b0, rand_patch());
    end
    wait_drain();
    test_id = 3;
    repeat (300) put_query(1'b1, rand_patch());
    put_query(1'b0, '0);
    wait_drain();
    test_id = 4;
    d = int'(root_word.split_dim);
    if (d > `KD_NUM_COMPS - 1) d = `KD_NUM_COMPS - 1;
    for (int n = 0; n < 64; n++) begin
      p = rand_patch();
      if (n[0] || root_word.threshold == 0) begin
        p.flat[d*`KD_COMP_WIDTH +: `KD_COMP_WIDTH] = root_word.threshold;         // Right
      end else begin
        p.flat[d*`KD_COMP_WIDTH +: `KD_COMP_WIDTH] = root_word.threshold - 1'b1;  // Left
      end
      put_query(1'b1, p);
      put_query(1'b0, '0);
    end
    wait_drain();
    test_id = 5;
    load_tree();  // Address counter wraps back to node 0
    repeat (150) put_query(1'b1, rand_patch());
    put_query(1'b0, '0);
    wait_drain();
    test_id = 6;
    repeat (300) put_query(1'($random(seed)), rand_patch());
    put_query(1'b0, '0);
    wait_drain();
    put_query(1'b0, '0);
    u_mon.print_summary(UUT.u_checker.fail_count);
    if (mon_errors == 0 && UUT.u_checker.fail_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+source
source/kd_pkg.sv
source/kd_node.sv
source/kd_node_loader.sv
source/kd_internal_tree.sv
source/kd_search_top.sv
dv/kd_clock_gen.sv
dv/kd_checker.sv
dv/kd_monitor.sv
dv/kd_tb.sv

// ==== source/kd_internal_tree.sv ====
/*
 Pipelined six-level tree of internal KD-tree nodes
 Per-level patch and one-hot valid registers, 63 generated nodes
 and the encoder from the bottom valid vector to the leaf index
*/

`timescale 1ns/1ps
`default_nettype none

`include "kd_params.svh"

module kd_internal_tree
  import kd_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     query_valid,
  input  patch_t                   query_patch,
  input  logic [`KD_NUM_NODES-1:0] node_wen,     // One strobe bit per heap node
  input  node_word_t               node_word,
  output logic                     leaf_valid,   // Six cycles after the query
  output logic [`KD_LEAF_WIDTH-1:0] leaf_index
);

  localparam int NUM_LEAVES = 1 << `KD_DEPTH;

  logic [NUM_LEAVES-1:0] leaf_vec_q;   // Registered bottom one-hot vector

  for (genvar i = 0; i < `KD_DEPTH; i++) begin : g_lvl
    localparam int N = 1 << i;         // Nodes in this level

    logic [N-1:0]   valid_d;           // Vector entering this level's register
    patch_t         patch_d;
    logic [N-1:0]   valid_q;           // Position of the patch within the level
    patch_t         patch_q;
    logic [2*N-1:0] valid_next;        // Child valid bits, feed the next level

    if (i == 0) begin : g_head
      // Root level samples the query port
      assign valid_d = query_valid;
      assign patch_d = query_patch;
    end else begin : g_body
      assign valid_d = g_lvl[i-1].valid_next;
      assign patch_d = g_lvl[i-1].patch_q;
    end

    // Valid vector register, cleared so no result leaks out of reset
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        valid_q <= '0;
      end else begin
        valid_q <= valid_d;
      end
    end

    // Patch just rides along
    always_ff @(posedge clk) begin
      patch_q <= patch_d;
    end

    for (genvar j = 0; j < N; j++) begin : g_node
      // Heap index of node j in level i is 2^i - 1 + j
      kd_node u_node (
        .clk         (clk),
        .rst_n       (rst_n),
        .wen         (node_wen[N-1+j]),
        .wdata       (node_word),
        .valid_in    (valid_q[j]),
        .patch       (patch_q),
        .valid_left  (valid_next[2*j]),    // Left child, path bit 0
        .valid_right (valid_next[2*j+1])   // Right child, path bit 1
      );
    end
  end

  // Bottom register, last stage of the six-cycle pipeline
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      leaf_vec_q <= '0;
    end else begin
      leaf_vec_q <= g_lvl[`KD_DEPTH-1].valid_next;
    end
  end

  // One-hot to binary, bit position equals the path taken
  always_comb begin
    leaf_index = '0;
    for (int b = 0; b < NUM_LEAVES; b++) begin
      if (leaf_vec_q[b]) begin
        leaf_index = leaf_index | `KD_LEAF_WIDTH'(b);
      end
    end
  end

  assign leaf_valid = |leaf_vec_q;  // At most one bit set per cycle

endmodule

`default_nettype wire

// ==== source/kd_node.sv ====
/*
 One internal KD-tree node
 Holds its split word, picks the split component of the passing patch
 and steers the valid bit to the left or right child
*/

`timescale 1ns/1ps
`default_nettype none

`include "kd_params.svh"

module kd_node
  import kd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       wen,          // One strobe bit from the loader
  input  node_word_t wdata,        // Shared write word
  input  logic       valid_in,     // This node's bit of the level vector
  input  patch_t     patch,        // Registered patch of this level
  output logic       valid_left,
  output logic       valid_right
);

  node_word_t                word_q;     // Split dimension and threshold
  logic [`KD_DIM_WIDTH-1:0]  dim_sel;    // Clamped split dimension
  logic [`KD_COMP_WIDTH-1:0] comp_val;   // Component under test
  logic                      go_right;

  // Node word store, zero after reset sends every patch right
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      word_q <= '0;
    end else if (wen) begin
      word_q <= wdata;
    end
  end

  // Dimensions 5 to 7 fall back to the last component
  assign dim_sel = (word_q.split_dim > `KD_DIM_WIDTH'(`KD_NUM_COMPS - 1)) ?
                   `KD_DIM_WIDTH'(`KD_NUM_COMPS - 1) : word_q.split_dim;

  assign comp_val = patch.comp[dim_sel];            // Array view of the union
  assign go_right = (comp_val >= word_q.threshold);  // Equal goes right

  // Exactly one child sees the valid bit
  assign valid_right = valid_in & go_right;
  assign valid_left  = valid_in & ~go_right;

endmodule

`default_nettype wire

// ==== source/kd_node_loader.sv ====
/*
 Node loader for the KD-tree
 Four-phase req/ack receiver, heap-order write address with wrap at 62,
 and one-hot write strobe for the 63 internal nodes
*/

`timescale 1ns/1ps
`default_nettype none

`include "kd_params.svh"

module kd_node_loader
  import kd_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     node_req,   // Host request, word valid while high
  input  node_word_t               node_wdata,
  output logic                     node_ack,
  output logic [`KD_NUM_NODES-1:0] node_wen,   // One-hot, one bit per node
  output node_word_t               node_word   // Word that goes with the strobe
);

  localparam int ADDR_W = $clog2(`KD_NUM_NODES);

  logic [ADDR_W-1:0] wr_addr;   // Next heap index to write
  logic              wr_pend;   // Strobe cycle of an accepted word
  logic              accept;    // New request this cycle
  node_word_t        word_q;

  // Only a fresh request, not one still waiting for its ack
  assign accept = node_req && !node_ack && !wr_pend;

  // Handshake and address state
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      node_ack <= 1'b0;
      wr_pend  <= 1'b0;
      wr_addr  <= '0;
    end else begin
      wr_pend <= accept;
      if (wr_pend) begin
        node_ack <= 1'b1;  // Ack goes up with the node write
        // Wrap so a second load replaces the whole tree
        wr_addr  <= (wr_addr == ADDR_W'(`KD_NUM_NODES - 1)) ? '0 : wr_addr + 1'b1;
      end else if (!node_req) begin
        node_ack <= 1'b0;  // Host has released the request
      end
    end
  end

  // Capture the word at the accepting edge
  always_ff @(posedge clk) begin
    if (accept) begin
      word_q <= node_wdata;
    end
  end

  // Address decoder, strobe only in the pending cycle
  always_comb begin
    node_wen = '0;
    if (wr_pend) begin
      node_wen[wr_addr] = 1'b1;
    end
  end

  assign node_word = word_q;

endmodule

`default_nettype wire

// ==== source/kd_params.svh ====
/*
 Shared sizes for the KD-tree search engine
 Patch components, tree depth, node-word fields and leaf index
*/

`ifndef KD_PARAMS_SVH
`define KD_PARAMS_SVH

// Patch geometry
`define KD_COMP_WIDTH   11                                 // One unsigned component
`define KD_NUM_COMPS    5                                  // Components per patch
`define KD_PATCH_WIDTH  (`KD_COMP_WIDTH * `KD_NUM_COMPS)   // 55 bit patch

// Tree geometry
`define KD_DEPTH        6                                  // Internal levels
`define KD_NUM_NODES    ((1 << `KD_DEPTH) - 1)             // 63 internal nodes, heap order
`define KD_LEAF_WIDTH   `KD_DEPTH                          // 64 leaves

// Node word layout, split dimension above threshold
`define KD_DIM_WIDTH    3
`define KD_NODE_WIDTH   (`KD_DIM_WIDTH + `KD_COMP_WIDTH)   // 14 bit node word

`endif

// ==== source/kd_pkg.sv ====
/*
 Types shared by the KD-tree search engine
 patch_t: flat and per-component views of one patch
 node_word_t: split dimension and threshold of an internal node
*/

`default_nettype none

`include "kd_params.svh"

package kd_pkg;

  // One patch word, read two ways
  typedef union packed {
    logic [`KD_PATCH_WIDTH-1:0]                   flat;  // Transport and pipeline view
    logic [`KD_NUM_COMPS-1:0][`KD_COMP_WIDTH-1:0] comp;  // Component 0 in the low bits
  } patch_t;

  // Stored in each internal node
  typedef struct packed {
    logic [`KD_DIM_WIDTH-1:0]                  split_dim;  // Values above 4 clamp to comp 4
    logic [`KD_NODE_WIDTH-`KD_DIM_WIDTH-1:0]   threshold;  // Unsigned, same width as a component
  } node_word_t;

endpackage

`default_nettype wire

// ==== source/kd_search_top.sv ====
/*
 Top level of the KD-tree search engine
 Node loader on the host side, pipelined internal tree on the query side
*/

`timescale 1ns/1ps
`default_nettype none

`include "kd_params.svh"

module kd_search_top
  import kd_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      node_req,     // Four-phase load request
  input  node_word_t                node_wdata,
  output logic                      node_ack,
  input  logic                      query_valid,  // One patch per cycle, no back-pressure
  input  patch_t                    query_patch,
  output logic                      leaf_valid,
  output logic [`KD_LEAF_WIDTH-1:0] leaf_index
);

  logic [`KD_NUM_NODES-1:0] node_wen;   // One-hot write strobe
  node_word_t               node_word;  // Word written under the strobe

  kd_node_loader u_loader (
    .clk        (clk),
    .rst_n      (rst_n),
    .node_req   (node_req),
    .node_wdata (node_wdata),
    .node_ack   (node_ack),
    .node_wen   (node_wen),
    .node_word  (node_word)
  );

  kd_internal_tree u_tree (
    .clk         (clk),
    .rst_n       (rst_n),
    .query_valid (query_valid),
    .query_patch (query_patch),
    .node_wen    (node_wen),
    .node_word   (node_word),
    .leaf_valid  (leaf_valid),
    .leaf_index  (leaf_index)
  );

endmodule

`default_nettype wire
